//--- isf_pkg.sv
// Shared constants, types and FSM encodings for the TLV staging FIFO support block.
`default_nettype none

package isf_pkg;

  localparam int ISF_FIFO_ENTRIES = 128;
  localparam int WMARK_STEP       = 8;
  localparam int DATA_W           = 64;
  localparam int WORD_NUM_W       = 21;

  // depth counts 0 to ISF_FIFO_ENTRIES inclusive, so one extra bit is needed.
  typedef logic [$clog2(ISF_FIFO_ENTRIES+1)-1:0] fifo_depth_t;
  typedef logic [2:0]                            wmark_sel_t;

  // code 3 was once single step and stays unused.
  typedef enum logic [2:0] {
    DBG_NORMAL      = 3'd0,
    DBG_BLK_RDWR    = 3'd1,
    DBG_BLK_RD      = 3'd2,
    DBG_TRIG_FREEZE = 3'd4
  } debug_mode_e;

  typedef enum logic [7:0] {
    TLV_RQE = 8'h01,
    TLV_CMD = 8'h02,
    TLV_CQE = 8'h03
  } tlv_type_e;

  typedef struct packed {
    logic [DATA_W-9:0] rsvd;
    tlv_type_e         tlv_type;
  } tlv_hdr_t;

  typedef union packed {
    logic [DATA_W-1:0] raw;
    tlv_hdr_t          hdr;
  } tlv_word_u;

  localparam logic [1:0] TF_IDLE = 2'd0;
  localparam logic [1:0] TF_CNT  = 2'd1;
  localparam logic [1:0] TF_HIT  = 2'd2;

  localparam logic [1:0] PS_IDLE = 2'd0;
  localparam logic [1:0] PS_RQE  = 2'd1;
  localparam logic [1:0] PS_CMD  = 2'd2;
  localparam logic [1:0] PS_CQE  = 2'd3;

endpackage

`default_nettype wire

//--- isf_tap_if.sv
// Downstream read tap shared by the flow control block and the trigger matcher.
`default_nettype none

interface isf_tap_if;

  logic               arm;
  logic               valid;
  logic               sop;
  isf_pkg::tlv_word_u data;
  logic               freeze;

  // the flow block owns the tap, the trigger block answers with freeze.
  modport flow (output arm, output valid, output sop, output data, input freeze);

  modport trig (input arm, input valid, input sop, input data, output freeze);

endinterface

`default_nettype wire

//--- isf_flow_ctl.sv
// Debug mode gating of the FIFO write and read strobes and the downstream read tap.
`default_nettype none

module isf_flow_ctl (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire isf_pkg::debug_mode_e debug_mode,
  input  wire                       force_ib_bp,
  input  wire                       fifo_full,
  input  wire                       axi_slv_empty,
  input  wire isf_pkg::fifo_depth_t isf_fifo_depth,
  input  wire                       pre_tlvp_fifo_afull,
  input  wire                       pre_tlvp_fifo_empty,
  input  wire                       pre_tlvp_fifo_rd,
  input  wire isf_pkg::tlv_word_u   tlv_tdata,
  input  wire                       tlv_sop,
  output logic                      isf_fifo_hw_wr,
  output logic                      isf_fifo_hw_rd,
  output logic                      pre_tlvp_fifo_wr,
  output logic                      pre_tlvp_fifo_empty_mod,
  isf_tap_if.flow                   tap
);

  logic fifo_empty;
  logic fifo_empty_mod;
  logic wr_ok;

  assign fifo_empty = (isf_fifo_depth == '0);
  assign wr_ok      = !axi_slv_empty && !fifo_full;

  // blocked reads are done by making the staging FIFO look empty.
  always_comb
  begin
    case (debug_mode)
      isf_pkg::DBG_NORMAL:
      begin
        fifo_empty_mod = fifo_empty;
        isf_fifo_hw_wr = wr_ok && !force_ib_bp;
      end
      isf_pkg::DBG_BLK_RDWR:
      begin
        fifo_empty_mod = 1'b1;
        isf_fifo_hw_wr = 1'b0;
      end
      isf_pkg::DBG_BLK_RD:
      begin
        fifo_empty_mod = 1'b1;
        isf_fifo_hw_wr = wr_ok;
      end
      default:
      begin
        fifo_empty_mod = fifo_empty;
        isf_fifo_hw_wr = wr_ok;
      end
    endcase
  end

  assign isf_fifo_hw_rd = !fifo_empty_mod && !pre_tlvp_fifo_afull;

  // freeze can only rise while the trigger is armed.
  assign pre_tlvp_fifo_empty_mod = pre_tlvp_fifo_empty || tap.freeze;

  assign tap.arm  = (debug_mode == isf_pkg::DBG_TRIG_FREEZE);
  assign tap.sop  = tlv_sop;
  assign tap.data = tlv_tdata;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pre_tlvp_fifo_wr <= 1'b0;
      tap.valid        <= 1'b0;
    end
    else
    begin
      pre_tlvp_fifo_wr <= isf_fifo_hw_rd;
      tap.valid        <= pre_tlvp_fifo_rd;
    end
  end

endmodule

`default_nettype wire

//--- isf_wmark_bp.sv
// Watermark back-pressure with hysteresis, producing the registered FIFO full flag.
`default_nettype none

module isf_wmark_bp (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire isf_pkg::fifo_depth_t isf_fifo_depth,
  input  wire isf_pkg::wmark_sel_t  use_wmark_sel,
  input  wire isf_pkg::wmark_sel_t  req_wmark_sel,
  output logic                      fifo_full
);

  isf_pkg::fifo_depth_t use_wmark;
  isf_pkg::fifo_depth_t req_wmark;
  isf_pkg::fifo_depth_t use_depth;
  isf_pkg::fifo_depth_t req_depth;
  logic                 use_hit;
  logic                 req_hit;

  assign use_wmark = isf_pkg::fifo_depth_t'((use_wmark_sel + 1) * isf_pkg::WMARK_STEP);
  assign req_wmark = isf_pkg::fifo_depth_t'((req_wmark_sel + 1) * isf_pkg::WMARK_STEP);

  // both watermarks together are at most 128, so this never wraps.
  assign use_depth = isf_pkg::fifo_depth_t'(isf_pkg::ISF_FIFO_ENTRIES) - use_wmark;
  assign req_depth = use_depth - req_wmark;

  assign use_hit = (isf_fifo_depth >= use_depth);
  assign req_hit = (isf_fifo_depth <= req_depth);

  // the flag itself is the state: it sets at the use mark and clears only
  // once the depth has drained past the request mark as well.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fifo_full <= 1'b0;
    end
    else if (!fifo_full && use_hit)
    begin
      fifo_full <= 1'b1;
    end
    else if (fifo_full && req_hit)
    begin
      fifo_full <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- isf_trig_freeze.sv
// Trigger matcher that finds the Nth word of a chosen TLV type and freezes downstream reads.
`default_nettype none

module isf_trig_freeze (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire isf_pkg::tlv_type_e           trig_tlv_type,
  input  wire [isf_pkg::WORD_NUM_W-1:0]     trig_word_num,
  input  wire [isf_pkg::DATA_W-1:0]         trig_match_val,
  input  wire [isf_pkg::DATA_W-1:0]         trig_mask_val,
  output logic                              trigger_hit,
  output logic [isf_pkg::DATA_W-1:0]        trig_cap,
  isf_tap_if.trig                           tap
);

  logic [1:0]                     state;
  logic [1:0]                     state_nxt;
  logic [isf_pkg::WORD_NUM_W-1:0] word_cnt;
  logic                           cnt_en;
  logic                           cnt_clr;
  logic                           cap_ld;
  logic                           hit_nxt;
  logic                           tlv_match;
  logic                           word_match;
  logic                           num_zero;
  logic                           cnt_match;

  // the same tap word is tested by type through the header view and by value raw.
  assign tlv_match  = tap.valid && tap.sop && tap.arm &&
                      (tap.data.hdr.tlv_type == trig_tlv_type);
  assign word_match = (((tap.data.raw ^ trig_match_val) & trig_mask_val) == '0);
  assign num_zero   = (trig_word_num == '0);
  assign cnt_match  = (word_cnt == trig_word_num);

  always_comb
  begin
    state_nxt = state;
    cnt_en    = 1'b0;
    cnt_clr   = 1'b0;
    cap_ld    = 1'b0;
    hit_nxt   = 1'b0;
    case (state)
      isf_pkg::TF_IDLE:
      begin
        if (tlv_match && !num_zero)
        begin
          cnt_en    = 1'b1;
          state_nxt = isf_pkg::TF_CNT;
        end
        else if (tlv_match && word_match)
        begin
          cap_ld    = 1'b1;
          hit_nxt   = 1'b1;
          state_nxt = isf_pkg::TF_HIT;
        end
      end
      isf_pkg::TF_CNT:
      begin
        if (!tap.arm || (tap.valid && cnt_match))
        begin
          cnt_clr   = 1'b1;
          cap_ld    = tap.arm && word_match;
          hit_nxt   = tap.arm && word_match;
          state_nxt = (tap.arm && word_match) ? isf_pkg::TF_HIT : isf_pkg::TF_IDLE;
        end
        else
        begin
          cnt_en = tap.valid;
        end
      end
      isf_pkg::TF_HIT:
      begin
        hit_nxt   = tap.arm;
        state_nxt = tap.arm ? isf_pkg::TF_HIT : isf_pkg::TF_IDLE;
      end
      default:
      begin
        state_nxt = isf_pkg::TF_IDLE;
      end
    endcase
  end

  assign tap.freeze = hit_nxt;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= isf_pkg::TF_IDLE;
      word_cnt    <= '0;
      trigger_hit <= 1'b0;
    end
    else
    begin
      state       <= state_nxt;
      trigger_hit <= hit_nxt;
      if (cnt_clr)
        word_cnt <= '0;
      else if (cnt_en)
        word_cnt <= word_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cap_ld)
      trig_cap <= tap.data.raw;
  end

endmodule

`default_nettype wire

//--- isf_stall_timer.sv
// Outbound stall timer that raises an interrupt after a run of back-pressured cycles.
`default_nettype none

module isf_stall_timer (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        sys_stall_en,
  input  wire [31:0] sys_stall_limit,
  input  wire        ob_tvalid,
  input  wire        ob_tready,
  output logic       sys_stall_intr
);

  logic        counting;
  logic [31:0] stall_cnt;
  logic        stalled;

  assign stalled = ob_tvalid && !ob_tready && sys_stall_en;

  // counting is the whole FSM: low is idle, high is the count state.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      counting       <= 1'b0;
      stall_cnt      <= '0;
      sys_stall_intr <= 1'b0;
    end
    else
    begin
      sys_stall_intr <= 1'b0;
      if (!counting)
      begin
        counting  <= stalled;
        stall_cnt <= stalled ? 32'd1 : 32'd0;
      end
      else if (stall_cnt == sys_stall_limit)
      begin
        // limit reached, fire once and start over.
        counting       <= 1'b0;
        stall_cnt      <= '0;
        sys_stall_intr <= 1'b1;
      end
      else if (stalled)
      begin
        stall_cnt <= stall_cnt + 32'd1;
      end
      else
      begin
        counting  <= 1'b0;
        stall_cnt <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- isf_ib_parser.sv
// Inbound TLV tracker reporting RQE and CQE arrivals and masking debug during a CMD.
`default_nettype none

module isf_ib_parser (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     axi_slv_tvalid,
  input  wire                     axi_slv_sop,
  input  wire                     axi_slv_eop,
  input  wire isf_pkg::tlv_word_u axi_slv_tdata,
  input  wire                     isf_fifo_hw_wr,
  output logic                    sup_rqe_rx,
  output logic                    sup_cqe_rx,
  output logic                    mask_debug
);

  logic [1:0] state;
  logic       beat;
  logic       sop_rqe;
  logic       sop_cmd;
  logic       sop_cqe;

  // a beat only counts when the FIFO actually takes it.
  assign beat    = axi_slv_tvalid && isf_fifo_hw_wr;
  assign sop_rqe = beat && axi_slv_sop && (axi_slv_tdata.hdr.tlv_type == isf_pkg::TLV_RQE);
  assign sop_cmd = beat && axi_slv_sop && (axi_slv_tdata.hdr.tlv_type == isf_pkg::TLV_CMD);
  assign sop_cqe = beat && axi_slv_sop && (axi_slv_tdata.hdr.tlv_type == isf_pkg::TLV_CQE);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= isf_pkg::PS_IDLE;
      sup_rqe_rx <= 1'b0;
      sup_cqe_rx <= 1'b0;
    end
    else
    begin
      sup_rqe_rx <= 1'b0;
      sup_cqe_rx <= 1'b0;
      case (state)
        isf_pkg::PS_IDLE:
        begin
          if (sop_rqe)
          begin
            sup_rqe_rx <= 1'b1;
            state      <= isf_pkg::PS_RQE;
          end
        end
        isf_pkg::PS_RQE:
        begin
          if (sop_cqe)
          begin
            sup_cqe_rx <= 1'b1;
            state      <= isf_pkg::PS_CQE;
          end
          else if (sop_cmd)
            state <= isf_pkg::PS_CMD;
        end
        // the CMD window closes on the very next accepted beat.
        isf_pkg::PS_CMD:
        begin
          if (beat)
            state <= isf_pkg::PS_RQE;
        end
        default:
        begin
          if (beat && axi_slv_eop)
            state <= isf_pkg::PS_IDLE;
        end
      endcase
    end
  end

  assign mask_debug = (state == isf_pkg::PS_CMD);

endmodule

`default_nettype wire

//--- isf_support.sv
// Top level of the staging FIFO support block, connecting the control sub-blocks.
`default_nettype none

module isf_support (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire isf_pkg::wmark_sel_t          use_wmark_sel,
  input  wire isf_pkg::wmark_sel_t          req_wmark_sel,
  input  wire isf_pkg::debug_mode_e         debug_mode,
  input  wire                               force_ib_bp,
  input  wire                               sys_stall_en,
  input  wire [31:0]                        sys_stall_limit,
  input  wire isf_pkg::tlv_type_e           trig_tlv_type,
  input  wire [isf_pkg::WORD_NUM_W-1:0]     trig_word_num,
  input  wire [isf_pkg::DATA_W-1:0]         trig_match_val,
  input  wire [isf_pkg::DATA_W-1:0]         trig_mask_val,
  input  wire                               axi_slv_empty,
  input  wire                               axi_slv_tvalid,
  input  wire                               axi_slv_sop,
  input  wire                               axi_slv_eop,
  input  wire isf_pkg::tlv_word_u           axi_slv_tdata,
  input  wire isf_pkg::fifo_depth_t         isf_fifo_depth,
  input  wire                               pre_tlvp_fifo_afull,
  input  wire                               pre_tlvp_fifo_empty,
  input  wire                               pre_tlvp_fifo_rd,
  input  wire isf_pkg::tlv_word_u           tlv_tdata,
  input  wire                               tlv_sop,
  input  wire                               ob_tvalid,
  input  wire                               ob_tready,
  output logic                              isf_fifo_hw_wr,
  output logic                              isf_fifo_hw_rd,
  output logic                              pre_tlvp_fifo_wr,
  output logic                              pre_tlvp_fifo_empty_mod,
  output logic                              trigger_hit,
  output logic [isf_pkg::DATA_W-1:0]        trig_cap,
  output logic                              sys_stall_intr,
  output logic                              sup_rqe_rx,
  output logic                              sup_cqe_rx,
  output logic                              mask_debug
);

  logic fifo_full;

  isf_tap_if tap ();

  isf_flow_ctl i_flow_ctl (
    .clk                     (clk),
    .rst_n                   (rst_n),
    .debug_mode              (debug_mode),
    .force_ib_bp             (force_ib_bp),
    .fifo_full               (fifo_full),
    .axi_slv_empty           (axi_slv_empty),
    .isf_fifo_depth          (isf_fifo_depth),
    .pre_tlvp_fifo_afull     (pre_tlvp_fifo_afull),
    .pre_tlvp_fifo_empty     (pre_tlvp_fifo_empty),
    .pre_tlvp_fifo_rd        (pre_tlvp_fifo_rd),
    .tlv_tdata               (tlv_tdata),
    .tlv_sop                 (tlv_sop),
    .isf_fifo_hw_wr          (isf_fifo_hw_wr),
    .isf_fifo_hw_rd          (isf_fifo_hw_rd),
    .pre_tlvp_fifo_wr        (pre_tlvp_fifo_wr),
    .pre_tlvp_fifo_empty_mod (pre_tlvp_fifo_empty_mod),
    .tap                     (tap.flow)
  );

  isf_wmark_bp i_wmark_bp (
    .clk            (clk),
    .rst_n          (rst_n),
    .isf_fifo_depth (isf_fifo_depth),
    .use_wmark_sel  (use_wmark_sel),
    .req_wmark_sel  (req_wmark_sel),
    .fifo_full      (fifo_full)
  );

  isf_trig_freeze i_trig_freeze (
    .clk            (clk),
    .rst_n          (rst_n),
    .trig_tlv_type  (trig_tlv_type),
    .trig_word_num  (trig_word_num),
    .trig_match_val (trig_match_val),
    .trig_mask_val  (trig_mask_val),
    .trigger_hit    (trigger_hit),
    .trig_cap       (trig_cap),
    .tap            (tap.trig)
  );

  isf_stall_timer i_stall_timer (
    .clk             (clk),
    .rst_n           (rst_n),
    .sys_stall_en    (sys_stall_en),
    .sys_stall_limit (sys_stall_limit),
    .ob_tvalid       (ob_tvalid),
    .ob_tready       (ob_tready),
    .sys_stall_intr  (sys_stall_intr)
  );

  isf_ib_parser i_ib_parser (
    .clk            (clk),
    .rst_n          (rst_n),
    .axi_slv_tvalid (axi_slv_tvalid),
    .axi_slv_sop    (axi_slv_sop),
    .axi_slv_eop    (axi_slv_eop),
    .axi_slv_tdata  (axi_slv_tdata),
    .isf_fifo_hw_wr (isf_fifo_hw_wr),
    .sup_rqe_rx     (sup_rqe_rx),
    .sup_cqe_rx     (sup_cqe_rx),
    .mask_debug     (mask_debug)
  );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
// Testbench clock and reset source, a 4 ns clock with reset held low for three cycles.
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- isf_support_assertions.sv
// Protocol assertions for the support block, bound onto the top level by the testbench.
`default_nettype none

module isf_support_assertions (
  input wire                       clk,
  input wire                       rst_n,
  input wire isf_pkg::debug_mode_e debug_mode,
  input wire                       pre_tlvp_fifo_afull,
  input wire                       isf_fifo_hw_rd,
  input wire                       isf_fifo_hw_wr,
  input wire                       sys_stall_intr
);

  timeunit 1ns;
  timeprecision 100ps;

  // a downstream read must wait while the staging FIFO is almost full.
  rd_waits_for_afull: assert property (@(posedge clk) disable iff (!rst_n)
    pre_tlvp_fifo_afull |-> !isf_fifo_hw_rd)
    else $error("hw_rd asserted while pre_tlvp_fifo_afull is high");

  no_write_in_blk_rdwr: assert property (@(posedge clk) disable iff (!rst_n)
    (debug_mode == isf_pkg::DBG_BLK_RDWR) |-> !isf_fifo_hw_wr)
    else $error("hw_wr asserted in blk_rdwr mode");

  // the stall interrupt is a pulse, never a level.
  intr_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    sys_stall_intr |=> !sys_stall_intr)
    else $error("sys_stall_intr stayed high for more than one cycle");

endmodule

`default_nettype wire

//--- tb_isf_support.sv
// Table-driven testbench for the staging FIFO support block, run through isf_support.f.
`default_nettype none

module tb_isf_support;

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    isf_pkg::debug_mode_e           mode;
    logic                           force_bp;
    isf_pkg::fifo_depth_t           depth;
    logic [isf_pkg::WORD_NUM_W-1:0] word_num;
    logic                           ib_valid;
    logic                           ib_sop;
    logic                           ib_eop;
    logic [7:0]                     ib_type;
    logic                           afull;
    logic                           pre_rd;
    logic                           pre_sop;
    logic [31:0]                    pre_lo;
    logic                           stall;
    logic [7:0]                     hold;
    // expected wr, rd, empty_mod, hit, intr, rqe, cqe, mask from msb down.
    logic [7:0]                     exp;
    // bit 0 records the tap word for capture, bit 1 checks trig_cap.
    logic [1:0]                     cap;
  } row_t;

  localparam isf_pkg::debug_mode_e NRM = isf_pkg::DBG_NORMAL;
  localparam isf_pkg::debug_mode_e BRW = isf_pkg::DBG_BLK_RDWR;
  localparam isf_pkg::debug_mode_e BRD = isf_pkg::DBG_BLK_RD;
  localparam isf_pkg::debug_mode_e TRG = isf_pkg::DBG_TRIG_FREEZE;

  logic                           clk;
  logic                           rst_n;
  isf_pkg::wmark_sel_t            use_wmark_sel;
  isf_pkg::wmark_sel_t            req_wmark_sel;
  isf_pkg::debug_mode_e           debug_mode;
  logic                           force_ib_bp;
  logic                           sys_stall_en;
  logic [31:0]                    sys_stall_limit;
  isf_pkg::tlv_type_e             trig_tlv_type;
  logic [isf_pkg::WORD_NUM_W-1:0] trig_word_num;
  logic [isf_pkg::DATA_W-1:0]     trig_match_val;
  logic [isf_pkg::DATA_W-1:0]     trig_mask_val;
  logic                           axi_slv_empty;
  logic                           axi_slv_tvalid;
  logic                           axi_slv_sop;
  logic                           axi_slv_eop;
  isf_pkg::tlv_word_u             axi_slv_tdata;
  isf_pkg::fifo_depth_t           isf_fifo_depth;
  logic                           pre_tlvp_fifo_afull;
  logic                           pre_tlvp_fifo_empty;
  logic                           pre_tlvp_fifo_rd;
  isf_pkg::tlv_word_u             tlv_tdata;
  logic                           tlv_sop;
  logic                           ob_tvalid;
  logic                           ob_tready;
  logic                           isf_fifo_hw_wr;
  logic                           isf_fifo_hw_rd;
  logic                           pre_tlvp_fifo_wr;
  logic                           pre_tlvp_fifo_empty_mod;
  logic                           trigger_hit;
  logic [isf_pkg::DATA_W-1:0]     trig_cap;
  logic                           sys_stall_intr;
  logic                           sup_rqe_rx;
  logic                           sup_cqe_rx;
  logic                           mask_debug;

  row_t               rows[$];
  logic [31:0]        seed = 32'h35a3_3d1c;
  isf_pkg::tlv_word_u cap_word;
  logic               pre_wr_exp;
  int                 errors = 0;
  int                 checks = 0;
  int                 cycles = 0;
  int                 cycle_limit = 100000;
  logic [31:0]        intr_count = 0;

  tb_clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

  isf_support i_isf_support (.*);

  bind isf_support isf_support_assertions i_isf_support_assertions (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic add_row(input isf_pkg::debug_mode_e mode, input logic force_bp,
                         input isf_pkg::fifo_depth_t depth, input logic [20:0] word_num,
                         input logic ib_valid, input logic ib_sop, input logic ib_eop,
                         input logic [7:0] ib_type, input logic afull, input logic pre_rd,
                         input logic pre_sop, input logic [31:0] pre_lo, input logic stall,
                         input logic [7:0] hold, input logic [7:0] exp, input logic [1:0] cap);
    row_t r;
    r = {mode, force_bp, depth, word_num, ib_valid, ib_sop, ib_eop, ib_type, afull,
         pre_rd, pre_sop, pre_lo, stall, hold, exp, cap};
    rows.push_back(r);
  endtask

  task automatic apply_row(input row_t r);
    logic [31:0]        fill;
    isf_pkg::tlv_word_u word;
    seed = xorshift(seed);
    fill = seed;
    seed = xorshift(seed);
    debug_mode          <= r.mode;
    force_ib_bp         <= r.force_bp;
    isf_fifo_depth      <= r.depth;
    trig_word_num       <= r.word_num;
    axi_slv_tvalid      <= r.ib_valid;
    axi_slv_sop         <= r.ib_sop;
    axi_slv_eop         <= r.ib_eop;
    axi_slv_tdata       <= {seed, fill[23:0], r.ib_type};
    pre_tlvp_fifo_afull <= r.afull;
    pre_tlvp_fifo_rd    <= r.pre_rd;
    tlv_sop             <= r.pre_sop;
    word                = {fill, r.pre_lo};
    tlv_tdata           <= word;
    ob_tvalid           <= r.stall;
    ob_tready           <= !r.stall;
    if (r.cap[0])
      cap_word = word;
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_word(input string name, input isf_pkg::tlv_word_u got,
                            input isf_pkg::tlv_word_u exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %s got %h exp %h at %0t", name, got.raw, exp.raw, $time);
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_row(input row_t r, input logic wr_exp);
    check_bit("isf_fifo_hw_wr", isf_fifo_hw_wr, r.exp[7]);
    check_bit("isf_fifo_hw_rd", isf_fifo_hw_rd, r.exp[6]);
    check_bit("pre_tlvp_fifo_wr", pre_tlvp_fifo_wr, wr_exp);
    check_bit("pre_tlvp_fifo_empty_mod", pre_tlvp_fifo_empty_mod, r.exp[5]);
    check_bit("trigger_hit", trigger_hit, r.exp[4]);
    check_bit("sys_stall_intr", sys_stall_intr, r.exp[3]);
    check_bit("sup_rqe_rx", sup_rqe_rx, r.exp[2]);
    check_bit("sup_cqe_rx", sup_cqe_rx, r.exp[1]);
    check_bit("mask_debug", mask_debug, r.exp[0]);
    if (r.cap[1])
      check_word("trig_cap", trig_cap, cap_word);
  endtask

  always @(posedge clk)
  begin
    cycles++;
    if (rst_n && sys_stall_intr === 1'b1)
      intr_count++;
    if (cycles > cycle_limit)
    begin
      $display("timeout: no verdict after %0d cycles", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial
  begin
    // mode gating at a steady depth of 16.
    add_row(NRM, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b1100_0000, 0);
    add_row(NRM, 1, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b0100_0000, 0);
    add_row(BRW, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b0000_0000, 0);
    add_row(BRW, 1, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b0000_0000, 0);
    add_row(BRD, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b1000_0000, 0);
    add_row(BRD, 1, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b1000_0000, 0);
    add_row(TRG, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b1100_0000, 0);
    add_row(NRM, 0, 16, 0, 0, 0, 0, 8'h00, 1, 0, 0, 32'h0, 0, 1, 8'b1000_0000, 0);
    add_row(NRM, 0, 0, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b1000_0000, 0);
    // both watermarks are 16 entries, so full sets at 112 and clears at 96.
    add_row(NRM, 0, 111, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b1100_0000, 0);
    add_row(NRM, 0, 112, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b0100_0000, 0);
    add_row(NRM, 0, 100, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b0100_0000, 0);
    add_row(NRM, 0, 97, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b0100_0000, 0);
    add_row(NRM, 0, 96, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b1100_0000, 0);
    add_row(NRM, 0, 100, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b1100_0000, 0);
    // trigger on the CQE header itself, then leave the freeze mode.
    add_row(TRG, 0, 16, 0, 0, 0, 0, 8'h00, 0, 1, 1, 32'hcafe_0003, 0, 2, 8'b1111_0000, 3);
    add_row(TRG, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b1111_0000, 2);
    add_row(NRM, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b1100_0000, 0);
    add_row(TRG, 0, 16, 0, 0, 0, 0, 8'h00, 0, 1, 1, 32'hcaff_0003, 0, 2, 8'b1100_0000, 0);
    // trigger on word 3 of a CQE, one tap word per row.
    add_row(TRG, 0, 16, 3, 0, 0, 0, 8'h00, 0, 1, 0, 32'h0, 0, 0, 8'b1100_0000, 0);
    add_row(TRG, 0, 16, 3, 0, 0, 0, 8'h00, 0, 1, 1, 32'h0000_0003, 0, 0, 8'b1100_0000, 0);
    add_row(TRG, 0, 16, 3, 0, 0, 0, 8'h00, 0, 1, 0, 32'h0000_1111, 0, 0, 8'b1100_0000, 0);
    add_row(TRG, 0, 16, 3, 0, 0, 0, 8'h00, 0, 1, 0, 32'h0000_2222, 0, 0, 8'b1100_0000, 0);
    add_row(TRG, 0, 16, 3, 0, 0, 0, 8'h00, 0, 1, 0, 32'hcafe_1234, 0, 0, 8'b1110_0000, 1);
    add_row(TRG, 0, 16, 3, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b1111_0000, 2);
    add_row(NRM, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b1100_0000, 0);
    // stall limit of 4, one full run and one broken run.
    add_row(NRM, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 1, 3, 8'b1100_0000, 0);
    add_row(NRM, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 1, 0, 8'b1100_0000, 0);
    add_row(NRM, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 0, 8'b1100_1000, 0);
    add_row(NRM, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 0, 8'b1100_0000, 0);
    add_row(NRM, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 1, 2, 8'b1100_0000, 0);
    add_row(NRM, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 0, 8'b1100_0000, 0);
    add_row(NRM, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 4, 8'b1100_0000, 0);
    // inbound sequence RQE, CMD, data, CQE, eop with some beats refused.
    add_row(NRM, 0, 16, 0, 1, 1, 0, 8'h01, 0, 0, 0, 32'h0, 0, 0, 8'b1100_0000, 0);
    add_row(NRM, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 0, 8'b1100_0100, 0);
    add_row(NRM, 0, 16, 0, 1, 1, 0, 8'h02, 0, 0, 0, 32'h0, 0, 0, 8'b1100_0000, 0);
    add_row(NRM, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b1100_0001, 0);
    add_row(NRM, 1, 16, 0, 1, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 1, 8'b0100_0001, 0);
    add_row(NRM, 0, 16, 0, 1, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 0, 8'b1100_0001, 0);
    add_row(NRM, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 0, 8'b1100_0000, 0);
    add_row(NRM, 1, 16, 0, 1, 1, 0, 8'h03, 0, 0, 0, 32'h0, 0, 0, 8'b0100_0000, 0);
    add_row(NRM, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 0, 8'b1100_0000, 0);
    add_row(NRM, 0, 16, 0, 1, 1, 0, 8'h03, 0, 0, 0, 32'h0, 0, 0, 8'b1100_0000, 0);
    add_row(NRM, 0, 16, 0, 1, 0, 1, 8'h00, 0, 0, 0, 32'h0, 0, 0, 8'b1100_0010, 0);
    add_row(NRM, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 0, 8'b1100_0000, 0);
    add_row(NRM, 0, 16, 0, 1, 1, 0, 8'h01, 0, 0, 0, 32'h0, 0, 0, 8'b1100_0000, 0);
    add_row(NRM, 0, 16, 0, 0, 0, 0, 8'h00, 0, 0, 0, 32'h0, 0, 0, 8'b1100_0100, 0);

    cycle_limit = 3 + 50;
    foreach (rows[i])
      cycle_limit += int'(rows[i].hold) + 1;

    use_wmark_sel       = 3'd1;
    req_wmark_sel       = 3'd1;
    debug_mode          = NRM;
    force_ib_bp         = 1'b0;
    sys_stall_en        = 1'b1;
    sys_stall_limit     = 32'd4;
    trig_tlv_type       = isf_pkg::TLV_CQE;
    trig_word_num       = '0;
    trig_match_val      = 64'h0000_0000_cafe_0000;
    trig_mask_val       = 64'h0000_0000_ffff_0000;
    axi_slv_empty       = 1'b0;
    axi_slv_tvalid      = 1'b0;
    axi_slv_sop         = 1'b0;
    axi_slv_eop         = 1'b0;
    axi_slv_tdata       = '0;
    isf_fifo_depth      = 8'd16;
    pre_tlvp_fifo_afull = 1'b0;
    pre_tlvp_fifo_empty = 1'b0;
    pre_tlvp_fifo_rd    = 1'b0;
    tlv_tdata           = '0;
    tlv_sop             = 1'b0;
    ob_tvalid           = 1'b0;
    ob_tready           = 1'b1;
    pre_wr_exp          = 1'b0;

    wait (rst_n === 1'b1);
    @(posedge clk);
    foreach (rows[i])
    begin
      apply_row(rows[i]);
      repeat (rows[i].hold) @(posedge clk);
      @(negedge clk);
      // the staging write follows the read strobe of the inputs seen at the last edge.
      if (rows[i].hold != 0)
        pre_wr_exp = rows[i].exp[6];
      check_row(rows[i], pre_wr_exp);
      pre_wr_exp = rows[i].exp[6];
      @(posedge clk);
    end
    check_count("sys_stall_intr pulses", intr_count, 32'd1);

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- isf_support.f
isf_pkg.sv
isf_tap_if.sv
isf_flow_ctl.sv
isf_wmark_bp.sv
isf_trig_freeze.sv
isf_stall_timer.sv
isf_ib_parser.sv
isf_support.sv
tb_clk_gen.sv
isf_support_assertions.sv
tb_isf_support.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the verdict.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_isf_support \
  -f isf_support.f \
  -o sim_isf_support

./obj_dir/sim_isf_support > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
